//--- logic/frv_lsu_pkg.sv
// Shared types and constants for the load/store unit and its data memory.
// Holds the access width and tracker state encodings, the request and
// response bundles, and the memory depth and wait-state count.

`default_nettype none

package frv_lsu_pkg;

    // ----------------------------------------
    // Memory geometry and timing
    // ----------------------------------------

    localparam int DMEM_DEPTH_WORDS = 256;                          // 32-bit words in the SRAM
    localparam int DMEM_WAIT_CYCLES = 2;                            // Stall cycles per access
    localparam int DMEM_IDX_W       = $clog2(DMEM_DEPTH_WORDS);     // Word index width
    localparam int DMEM_WAIT_W      = $clog2(DMEM_WAIT_CYCLES + 1); // Wait counter width

    // First byte address past the end of the memory
    localparam logic [31:0] DMEM_LIMIT_BYTES = 32'(DMEM_DEPTH_WORDS * 4);

    // ----------------------------------------
    // Encodings
    // ----------------------------------------

    typedef enum logic [1:0] {
        LSU_BYTE = 2'b00,                   // 8-bit access
        LSU_HALF = 2'b01,                   // 16-bit access
        LSU_WORD = 2'b10                    // 32-bit access
    } lsu_width_e;

    typedef enum logic {
        LSU_IDLE = 1'b0,                    // No finished access pending
        LSU_HELD = 1'b1                     // Done, waiting for pipe_prog
    } lsu_state_e;

    // ----------------------------------------
    // Bundles
    // ----------------------------------------

    typedef struct packed {
        logic [31:0] addr;                  // Byte address
        logic [31:0] wdata;                 // Store data, already lane placed
        logic        load;                  // Load access
        logic        store;                 // Store access
        lsu_width_e  width;                 // Access width
        logic        sign_ext;              // Sign extend load data
    } lsu_req_t;

    typedef struct packed {
        logic [31:0] rdata;                 // Steered load data
        logic        a_error;               // Misaligned access
        logic        b_error;               // Bus error on completion
        logic        ready;                 // Access complete
    } lsu_rsp_t;

    typedef struct packed {
        logic        cen;                   // Chip enable
        logic        wen;                   // Write enable
        logic [3:0]  strb;                  // Byte lane strobes
        logic [31:0] addr;                  // Word aligned address
        logic [31:0] wdata;                 // Write data
    } dmem_req_t;

    typedef struct packed {
        logic [31:0] rdata;                 // Read word
        logic        error;                 // Address out of range
        logic        stall;                 // Wait state
    } dmem_rsp_t;

endpackage

`default_nettype wire

//--- logic/lsu_track_fsm.sv
// Completion tracker of the load/store unit.
// Gates the chip enable and holds ready high after a finished access
// until the pipeline progresses, so one request never hits memory twice.

`timescale 1ns/100ps
`default_nettype none

module lsu_track_fsm (
    input  wire  g_clk,                         // Clock
    input  wire  g_resetn,                      // Sync reset, active low
    input  wire  lsu_valid,                     // Execute stage request level
    input  wire  a_error,                       // Misaligned request
    input  wire  pipe_prog,                     // Pipeline moves on this cycle
    input  wire  stall,                         // Memory wait state
    output logic cen,                           // Memory chip enable
    output logic ready                          // Access complete
);

    frv_lsu_pkg::lsu_state_e state;             // Current state
    frv_lsu_pkg::lsu_state_e state_nxt;         // Next state
    logic                    txn_done;          // Memory access finishes now

    // ----------------------------------------
    // Bus side
    // ----------------------------------------

    assign cen      = lsu_valid && !a_error && (state == frv_lsu_pkg::LSU_IDLE);
    assign txn_done = cen && !stall;            // Enabled and no wait state
    assign ready    = txn_done || (state == frv_lsu_pkg::LSU_HELD);

    // ----------------------------------------
    // State update
    // ----------------------------------------

    always_comb begin
        state_nxt = state;                      // Hold by default
        case (state)
            frv_lsu_pkg::LSU_IDLE: begin
                if (txn_done && !pipe_prog) begin
                    state_nxt = frv_lsu_pkg::LSU_HELD;  // Result not consumed yet
                end
            end
            frv_lsu_pkg::LSU_HELD: begin
                if (pipe_prog) begin
                    state_nxt = frv_lsu_pkg::LSU_IDLE;  // Consumed, free again
                end
            end
            default: state_nxt = frv_lsu_pkg::LSU_IDLE;
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state <= frv_lsu_pkg::LSU_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

`default_nettype wire

//--- logic/lsu_lane_steer.sv
// Byte-lane logic of the load/store unit, purely combinational.
// Checks alignment, builds write strobes and the word address, and
// selects plus extends the addressed bytes of the memory read word.

`timescale 1ns/100ps
`default_nettype none

module lsu_lane_steer (
    input  frv_lsu_pkg::lsu_req_t lsu_req,      // Request from execute stage
    input  wire  [31:0]           mem_rdata,    // Word from memory
    output logic                  a_error,      // Misaligned access
    output logic [3:0]            strb,         // Write lane strobes
    output logic [31:0]           word_addr,    // Word aligned bus address
    output logic [31:0]           wdata,        // Bus write data
    output logic [31:0]           rdata         // Extended load data
);

    logic        access;                        // A load or store is present
    logic [1:0]  offs;                          // Byte offset in word
    logic [7:0]  sel_byte;                      // Addressed byte
    logic [15:0] sel_half;                      // Addressed halfword

    assign access = lsu_req.load || lsu_req.store;
    assign offs   = lsu_req.addr[1:0];

    // ----------------------------------------
    // Alignment and bus fields
    // ----------------------------------------

    always_comb begin
        a_error = 1'b0;
        if (access) begin
            case (lsu_req.width)
                frv_lsu_pkg::LSU_HALF: a_error = offs[0];       // Odd halfword
                frv_lsu_pkg::LSU_WORD: a_error = |offs;         // Word off boundary
                default:               a_error = 1'b0;          // Bytes always fit
            endcase
        end
    end

    always_comb begin
        case (lsu_req.width)
            frv_lsu_pkg::LSU_BYTE: strb = 4'b0001 << offs;      // One lane
            frv_lsu_pkg::LSU_HALF: strb = offs[1] ? 4'b1100 : 4'b0011;
            frv_lsu_pkg::LSU_WORD: strb = 4'b1111;              // All lanes
            default:               strb = 4'b0000;
        endcase
    end

    assign word_addr = {lsu_req.addr[31:2], 2'b00};             // Drop byte offset
    assign wdata     = lsu_req.wdata;           // Caller already placed lanes

    // ----------------------------------------
    // Load data steering
    // ----------------------------------------

    always_comb begin
        case (offs)
            2'b00:   sel_byte = mem_rdata[7:0];
            2'b01:   sel_byte = mem_rdata[15:8];
            2'b10:   sel_byte = mem_rdata[23:16];
            default: sel_byte = mem_rdata[31:24];
        endcase
    end

    assign sel_half = offs[1] ? mem_rdata[31:16] : mem_rdata[15:0];

    always_comb begin
        case (lsu_req.width)
            frv_lsu_pkg::LSU_BYTE:
                rdata = {{24{lsu_req.sign_ext && sel_byte[7]}}, sel_byte};
            frv_lsu_pkg::LSU_HALF:
                rdata = {{16{lsu_req.sign_ext && sel_half[15]}}, sel_half};
            default:
                rdata = mem_rdata;              // Full word, no extension
        endcase
    end

endmodule

`default_nettype wire

//--- logic/dmem_wait_timer.sv
// Wait-state generator for the data memory.
// Stalls the first DMEM_WAIT_CYCLES cycles of every chip enable run,
// then lets the access complete and starts over.

`timescale 1ns/100ps
`default_nettype none

module dmem_wait_timer (
    input  wire  g_clk,                         // Clock
    input  wire  g_resetn,                      // Sync reset, active low
    input  wire  cen,                           // Memory chip enable
    output logic stall                          // Wait state
);

    logic [frv_lsu_pkg::DMEM_WAIT_W-1:0] count;    // Stalled cycles so far

    assign stall = cen && (count < frv_lsu_pkg::DMEM_WAIT_W'(frv_lsu_pkg::DMEM_WAIT_CYCLES));

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            count <= '0;
        end else if (!cen || !stall) begin
            count <= '0;                        // Idle or access done
        end else begin
            count <= count + frv_lsu_pkg::DMEM_WAIT_W'(1);  // One more wait state
        end
    end

endmodule

`default_nettype wire

//--- logic/dmem_sram.sv
// Tightly coupled data memory, one 32-bit word per entry.
// Reads are combinational from the word address; strobed lanes are
// written at the edge that ends a done cycle. Out-of-range addresses
// give a bus error, read as zero and are never written.

`timescale 1ns/100ps
`default_nettype none

module dmem_sram (
    input  wire                    g_clk,       // Clock
    input  wire                    g_resetn,    // Sync reset, active low
    input  frv_lsu_pkg::dmem_req_t dmem_req,    // Bus request
    input  wire                    stall,       // Wait state from timer
    output logic [31:0]            rdata,       // Read word
    output logic                   error        // Address out of range
);

    logic [31:0] mem [frv_lsu_pkg::DMEM_DEPTH_WORDS];  // Storage array

    logic [frv_lsu_pkg::DMEM_IDX_W-1:0] idx;    // Word index
    logic                               in_range;   // Address inside memory
    logic                               wr_en;      // Write this edge

    // ----------------------------------------
    // Decode
    // ----------------------------------------

    assign idx      = dmem_req.addr[frv_lsu_pkg::DMEM_IDX_W+1:2];
    assign in_range = dmem_req.addr < frv_lsu_pkg::DMEM_LIMIT_BYTES;
    assign error    = !in_range;

    // Done cycle of an in-range store, held off during reset
    assign wr_en = g_resetn && dmem_req.cen && !stall && dmem_req.wen && in_range;

    // ----------------------------------------
    // Read and write ports
    // ----------------------------------------

    assign rdata = in_range ? mem[idx] : 32'h0; // Zero on bus error

    always_ff @(posedge g_clk) begin
        if (wr_en) begin
            for (int i = 0; i < 4; i++) begin
                if (dmem_req.strb[i]) begin
                    mem[idx][8*i +: 8] <= dmem_req.wdata[8*i +: 8];  // Strobed lane
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/lsu_dmem_top.sv
// Load/store unit with its tightly coupled data memory.
// The execute stage drives lsu_valid and lsu_req and watches lsu_rsp;
// memory wait states come from the timer, errors from the SRAM.

`timescale 1ns/100ps
`default_nettype none

module lsu_dmem_top (
    input  wire                   g_clk,        // Clock
    input  wire                   g_resetn,     // Sync reset, active low
    input  wire                   lsu_valid,    // Request level
    input  frv_lsu_pkg::lsu_req_t lsu_req,      // Access request
    input  wire                   pipe_prog,    // Pipeline moves on
    output frv_lsu_pkg::lsu_rsp_t lsu_rsp       // Access response
);

    // ----------------------------------------
    // Internal nets
    // ----------------------------------------

    frv_lsu_pkg::dmem_req_t dmem_req;           // Memory bus request
    frv_lsu_pkg::dmem_rsp_t dmem_rsp;           // Memory bus response

    logic        cen;                           // Chip enable from tracker
    logic        ready;                         // Completion level
    logic        a_error;                       // Misalignment
    logic        b_error;                       // Bus error on done
    logic        stall;                         // Wait state
    logic [3:0]  strb;                          // Lane strobes
    logic [31:0] word_addr;                     // Aligned address
    logic [31:0] wdata;                         // Store data
    logic [31:0] load_data;                     // Steered load data
    logic [31:0] mem_rdata;                     // Raw read word
    logic        mem_error;                     // Out of range

    assign dmem_req = '{cen: cen, wen: lsu_req.store, strb: strb,
                        addr: word_addr, wdata: wdata};
    assign dmem_rsp = '{rdata: mem_rdata, error: mem_error, stall: stall};

    assign b_error = dmem_req.cen && !dmem_rsp.stall && dmem_rsp.error;
    assign lsu_rsp = '{rdata: load_data, a_error: a_error,
                       b_error: b_error, ready: ready};

    // ----------------------------------------
    // Blocks
    // ----------------------------------------

    lsu_track_fsm u_track (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .lsu_valid(lsu_valid),
        .a_error  (a_error),
        .pipe_prog(pipe_prog),
        .stall    (dmem_rsp.stall),
        .cen      (cen),
        .ready    (ready)
    );

    lsu_lane_steer u_steer (
        .lsu_req  (lsu_req),
        .mem_rdata(dmem_rsp.rdata),
        .a_error  (a_error),
        .strb     (strb),
        .word_addr(word_addr),
        .wdata    (wdata),
        .rdata    (load_data)
    );

    dmem_wait_timer u_timer (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .cen      (dmem_req.cen),
        .stall    (stall)
    );

    dmem_sram u_sram (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .dmem_req (dmem_req),
        .stall    (dmem_rsp.stall),
        .rdata    (mem_rdata),
        .error    (mem_error)
    );

endmodule

`default_nettype wire

//--- tb/lsu_props.sv
// Bus and completion rules for the load/store unit, bound into its top level.
// Sampled on every clock edge once reset is released.

`timescale 1ns/100ps
`default_nettype none

module lsu_props (
    input wire g_clk,                           // Clock
    input wire g_resetn,                        // Sync reset, active low
    input wire cen,                             // Memory chip enable
    input wire stall,                           // Memory wait state
    input wire a_error,                         // Misaligned access
    input wire ready                            // Access complete
);

    // Wait states only inside an enabled access
    stall_needs_cen: assert property (@(posedge g_clk) disable iff (!g_resetn) stall |-> cen)
        else $error("stall high while cen is low");

    // Misaligned requests never reach memory
    no_cen_on_misalign: assert property (@(posedge g_clk) disable iff (!g_resetn)
        a_error |-> !cen)
        else $error("cen high together with a_error");

    no_ready_on_misalign: assert property (@(posedge g_clk) disable iff (!g_resetn)
        !(ready && a_error))
        else $error("ready high together with a_error");

endmodule

bind lsu_dmem_top lsu_props u_props (
    .g_clk   (g_clk),
    .g_resetn(g_resetn),
    .cen     (cen),
    .stall   (stall),
    .a_error (a_error),
    .ready   (ready)
);

`default_nettype wire

//--- tb/lsu_tb.sv
// Self-checking testbench for the load/store unit with its data memory.
// Plays the execute stage, mirrors the memory in a shadow array and
// checks every response against a reference model of the access rules.

`timescale 1ns/100ps
`default_nettype none

module lsu_tb;

    localparam int WAIT    = frv_lsu_pkg::DMEM_WAIT_CYCLES;
    localparam int T1_N    = 16;                                    // Round trip pairs
    localparam int N_ACC   = frv_lsu_pkg::DMEM_DEPTH_WORDS + 2 * T1_N + 43;  // All accesses
    localparam int LAT_MAX = 4 * (WAIT + 1);                        // Per access limit

    logic                  g_clk;
    logic                  g_resetn;
    logic                  lsu_valid;
    logic                  pipe_prog;
    frv_lsu_pkg::lsu_req_t lsu_req;
    frv_lsu_pkg::lsu_rsp_t lsu_rsp;

    logic [31:0] shadow [frv_lsu_pkg::DMEM_DEPTH_WORDS];   // Expected memory
    integer      seed;                                      // $random state
    int          pass_cnt;
    int          fail_cnt;
    int          test_err;                                  // Errors in current test

    // ----------------------------------------
    // Sampled response and expectations
    // ----------------------------------------

    frv_lsu_pkg::lsu_rsp_t got_rsp;             // lsu_rsp at ready or a_error
    int          got_lat;                       // Cycles from valid to response
    int          got_extra;                     // Ready cycles after the response
    logic [31:0] exp_rdata;
    logic        exp_ready;
    logic        exp_a_error;
    logic        exp_b_error;
    logic        chk_rdata;                     // Loads only
    int          exp_lat;
    int          exp_extra;
    event        cmp_ev;                        // Starts a compare

    lsu_dmem_top uut (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .lsu_valid(lsu_valid),
        .lsu_req  (lsu_req),
        .pipe_prog(pipe_prog),
        .lsu_rsp  (lsu_rsp)
    );

    initial begin
        g_clk = 1'b0;
        forever #2 g_clk = ~g_clk;              // 4 ns period
    end

    initial begin
        repeat (N_ACC * (WAIT + 6) + 100) @(posedge g_clk);
        $display("Timeout: the run did not finish within its cycle budget");
        $display("Test failed");
        $finish;
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------

    function automatic logic [31:0] expect_load(input logic [31:0] word, input logic [31:0] addr,
                                                input frv_lsu_pkg::lsu_width_e width,
                                                input logic sign);
        logic [31:0] lane;
        lane = word >> (8 * addr[1:0]);         // Addressed bytes down to bit 0
        case (width)
            frv_lsu_pkg::LSU_BYTE: return sign ? 32'($signed(lane[7:0])) : 32'(lane[7:0]);
            frv_lsu_pkg::LSU_HALF: return sign ? 32'($signed(lane[15:0])) : 32'(lane[15:0]);
            default:               return word;
        endcase
    endfunction

    function automatic logic [31:0] lane_mask(input logic [31:0] addr,
                                              input frv_lsu_pkg::lsu_width_e width);
        case (width)
            frv_lsu_pkg::LSU_BYTE: return 32'h0000_00ff << (8 * addr[1:0]);
            frv_lsu_pkg::LSU_HALF: return 32'h0000_ffff << (8 * addr[1:0]);
            default:               return 32'hffff_ffff;
        endcase
    endfunction

    function automatic logic [31:0] rand_addr();
        return ($unsigned($random(seed)) % frv_lsu_pkg::DMEM_LIMIT_BYTES) & ~32'h3;
    endfunction

    // ----------------------------------------
    // Stimulus and compare
    // ----------------------------------------

    task automatic do_access(input logic is_store, input logic [31:0] addr,
                             input frv_lsu_pkg::lsu_width_e width, input logic sign,
                             input logic [31:0] data, input int hold);
        @(posedge g_clk);
        lsu_valid <= 1'b1;
        lsu_req   <= '{addr: addr, wdata: data, load: !is_store, store: is_store,
                       width: width, sign_ext: sign};
        pipe_prog <= (hold == 0);               // Low keeps the result pending
        got_lat   = 0;
        got_extra = 0;
        do begin
            @(negedge g_clk);
            got_lat++;
        end while (!lsu_rsp.ready && !lsu_rsp.a_error && got_lat < LAT_MAX);
        got_rsp = lsu_rsp;
        assert (got_rsp.ready || got_rsp.a_error) else begin
            $display("Neither ready nor a_error came within %0d cycles", LAT_MAX);
            fail_cnt++;
            test_err++;
        end
        repeat (got_rsp.a_error ? WAIT + 2 : hold) begin   // Watch ready afterwards
            @(negedge g_clk);
            got_extra += lsu_rsp.ready;
        end
        if (hold > 0) begin
            @(posedge g_clk);
            pipe_prog <= 1'b1;                  // Consume the held result
        end
        @(posedge g_clk);
        lsu_valid <= 1'b0;
        @(negedge g_clk);
        got_extra += lsu_rsp.ready;             // Must drop once released
    endtask

    task automatic access_and_check(input logic is_store, input logic [31:0] addr,
                                    input frv_lsu_pkg::lsu_width_e width, input logic sign,
                                    input logic [31:0] data, input int hold);
        logic        mis;
        logic        oor;
        logic [31:0] old;
        mis = (width == frv_lsu_pkg::LSU_HALF && addr[0]) ||
              (width == frv_lsu_pkg::LSU_WORD && addr[1:0] != 2'b00);
        oor = addr >= frv_lsu_pkg::DMEM_LIMIT_BYTES;
        old = oor ? 32'h0 : shadow[addr >> 2];  // Out of range reads zero
        do_access(is_store, addr, width, sign, data, hold);
        exp_ready   = !mis;
        exp_a_error = mis;
        exp_b_error = !mis && oor;
        exp_lat     = mis ? 1 : WAIT + 1;
        exp_extra   = mis ? 0 : hold;
        chk_rdata   = !is_store && !mis;
        exp_rdata   = expect_load(old, addr, width, sign);
        if (is_store && !mis && !oor) begin
            shadow[addr >> 2] = (old & ~lane_mask(addr, width)) | (data & lane_mask(addr, width));
        end
        -> cmp_ev;
        @(negedge g_clk);                       // Compare runs before the next access
    endtask

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        assert (got === exp) begin
            pass_cnt++;
        end else begin
            $display("[FAIL] %s expected %h got %h", name, exp, got);
            fail_cnt++;
            test_err++;
        end
    endtask

    always @(cmp_ev) begin
        compare_value("lsu_rsp.ready", exp_ready, got_rsp.ready);
        compare_value("lsu_rsp.a_error", exp_a_error, got_rsp.a_error);
        compare_value("lsu_rsp.b_error", exp_b_error, got_rsp.b_error);
        compare_value("ready latency", exp_lat, got_lat);
        compare_value("lsu_rsp.ready after response", exp_extra, got_extra);
        if (chk_rdata) begin
            compare_value("lsu_rsp.rdata", exp_rdata, got_rsp.rdata);
        end
    end

    task automatic finish_test(input string name);
        $display("%-20s : %s", name, (test_err == 0) ? "pass" : "FAIL");
        test_err = 0;
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------

    initial begin
        logic [31:0] base;
        logic [31:0] pat;
        logic [31:0] addrs [T1_N];
        int          i;
        int          j;
        seed      = 32'h1294a0b6;
        pass_cnt  = 0;
        fail_cnt  = 0;
        test_err  = 0;
        g_resetn  = 1'b0;
        lsu_valid = 1'b0;
        lsu_req   = '0;
        pipe_prog = 1'b1;
        repeat (3) @(posedge g_clk);
        g_resetn <= 1'b1;

        for (i = 0; i < frv_lsu_pkg::DMEM_DEPTH_WORDS; i++) begin    // Known contents
            access_and_check(1'b1, 32'(4 * i), frv_lsu_pkg::LSU_WORD, 1'b0, $random(seed), 0);
        end
        finish_test("memory fill");

        for (i = 0; i < T1_N; i++) begin
            addrs[i] = rand_addr();
            access_and_check(1'b1, addrs[i], frv_lsu_pkg::LSU_WORD, 1'b0, $random(seed), 0);
        end
        for (i = 0; i < T1_N; i++) begin
            access_and_check(1'b0, addrs[i], frv_lsu_pkg::LSU_WORD, 1'b0, 32'h0, 0);
        end
        finish_test("word round trip");

        base = rand_addr();
        for (i = 0; i < 4; i++) begin
            access_and_check(1'b1, base + i, frv_lsu_pkg::LSU_BYTE, 1'b0, $random(seed), 0);
        end
        for (i = 0; i < 4; i += 2) begin
            access_and_check(1'b1, base + i, frv_lsu_pkg::LSU_HALF, 1'b0, $random(seed), 0);
        end
        access_and_check(1'b0, base, frv_lsu_pkg::LSU_WORD, 1'b0, 32'h0, 0);
        finish_test("sub-word merge");

        for (j = 0; j < 2; j++) begin
            base = rand_addr();
            pat  = (j == 0) ? 32'hf0e1_9b87 : ($random(seed) | 32'h8080_8080);  // Sign bits set
            access_and_check(1'b1, base, frv_lsu_pkg::LSU_WORD, 1'b0, pat, 0);
            for (i = 0; i < 8; i++) begin
                access_and_check(1'b0, base + i / 2, frv_lsu_pkg::LSU_BYTE, i[0], 32'h0, 0);
            end
            for (i = 0; i < 4; i++) begin
                access_and_check(1'b0, base + 2 * (i / 2), frv_lsu_pkg::LSU_HALF, i[0],
                                 32'h0, 0);
            end
        end
        finish_test("load extension");

        base = rand_addr();
        access_and_check(1'b1, base + 1, frv_lsu_pkg::LSU_HALF, 1'b0, $random(seed), 0);
        access_and_check(1'b1, base + 2, frv_lsu_pkg::LSU_WORD, 1'b0, $random(seed), 0);
        access_and_check(1'b0, base + 3, frv_lsu_pkg::LSU_HALF, 1'b1, 32'h0, 0);
        access_and_check(1'b0, base + 1, frv_lsu_pkg::LSU_WORD, 1'b0, 32'h0, 0);
        access_and_check(1'b0, base, frv_lsu_pkg::LSU_WORD, 1'b0, 32'h0, 0);   // Unchanged
        finish_test("address error");

        base = rand_addr();                     // Same word index as the bad address
        access_and_check(1'b0, frv_lsu_pkg::DMEM_LIMIT_BYTES + base, frv_lsu_pkg::LSU_WORD,
                         1'b0, 32'h0, 0);
        access_and_check(1'b1, frv_lsu_pkg::DMEM_LIMIT_BYTES + base, frv_lsu_pkg::LSU_WORD,
                         1'b0, $random(seed), 0);
        access_and_check(1'b0, base, frv_lsu_pkg::LSU_WORD, 1'b0, 32'h0, 0);
        finish_test("bus error");

        base = rand_addr();
        access_and_check(1'b1, base, frv_lsu_pkg::LSU_WORD, 1'b0, $random(seed), 5);
        access_and_check(1'b0, base, frv_lsu_pkg::LSU_WORD, 1'b0, 32'h0, 0);
        finish_test("pipeline hold");

        $display("Checks passed: %0d, checks failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
logic/frv_lsu_pkg.sv
logic/lsu_track_fsm.sv
logic/lsu_lane_steer.sv
logic/dmem_wait_timer.sv
logic/dmem_sram.sv
logic/lsu_dmem_top.sv
tb/lsu_props.sv
tb/lsu_tb.sv
